// ==== project.f ====
+incdir+include
src/fdc_pkg.sv
src/fdc_host_regs.sv
src/fdc_seek_engine.sv
src/fdc_status_irq.sv
src/fdc_top.sv
verification/fdc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fdc_tb -f project.f -o fdc_sim

out=$(./obj_dir/fdc_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
exit 1

// ==== verification/fdc_tb.sv ====
// head model clamps to tracks 0 to 79 and a restore with trk00 stuck runs about 5100 cycles
`include "fdc_settings.svh"

module fdc_tb;

	// one command table row
	typedef struct packed {
		logic       head_set;
		logic [7:0] head_val;
		logic       stuck;
		logic       data_wr;
		logic [7:0] data_val;
		logic [7:0] cmd;
		logic [7:0] exp_track;
		logic [7:0] exp_steps;
		logic       exp_dir;
		logic [2:0] exp_st;
	} row_t;

	localparam int NROWS = 13;

	logic       clk;
	logic       rst_n;
	logic       cs_n;
	logic       re_n;
	logic       we_n;
	logic [1:0] addr;
	logic [7:0] din;
	logic [7:0] dout;
	logic       intrq;
	logic       step_n;
	logic       dir_n;
	logic       trk00_n = 1'b0;
	logic       index_n = 1'b1;
	logic       ready_n;
	logic       wprot_n;
	logic       hld;

	// drive model state
	int          head_pos = 0;
	int          fall_count = 0;
	logic        step_q = 1'b1;
	logic        pos_load;
	int          pos_value;
	logic        count_clr;
	// holds trk00_n high whatever the head position
	logic        stuck;
	logic [31:0] lcg_state = 32'd83519;

	row_t rows [NROWS];

	fdc_top uut (
		.clk(clk), .rst_n(rst_n),
		.cs_n(cs_n), .re_n(re_n), .we_n(we_n), .addr(addr), .din(din), .dout(dout),
		.intrq(intrq), .step_n(step_n), .dir_n(dir_n),
		.trk00_n(trk00_n), .index_n(index_n), .ready_n(ready_n), .wprot_n(wprot_n),
		.hld(hld)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// step falls are sampled on clk and seen one cycle late
	always @(posedge clk) begin
		step_q <= step_n;
		if (pos_load)
			head_pos <= pos_value;
		else if (step_q && !step_n) begin
			if (!dir_n && head_pos < 79)
				head_pos <= head_pos + 1;
			else if (dir_n && head_pos > 0)
				head_pos <= head_pos - 1;
		end
		if (count_clr)
			fall_count <= 0;
		else if (step_q && !step_n)
			fall_count <= fall_count + 1;
		trk00_n <= stuck || head_pos != 0;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// index pulses at random
	always @(posedge clk) begin
		lcg_state = lcg_next(lcg_state);
		if (lcg_state[23:20] == 4'd0)
			index_n <= !index_n;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic give_up(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// strobes stay low for two cycles
	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		int i;
		@(posedge clk);
		cs_n <= 1'b0;
		addr <= a;
		din  <= d;
		we_n <= 1'b0;
		for (i = 0; i < 2; i++)
			@(posedge clk);
		we_n <= 1'b1;
		cs_n <= 1'b1;
	endtask

	task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
		int i;
		@(posedge clk);
		cs_n <= 1'b0;
		addr <= a;
		re_n <= 1'b0;
		for (i = 0; i < 2; i++)
			@(posedge clk);
		d = dout;
		re_n <= 1'b1;
		cs_n <= 1'b1;
	endtask

	task automatic clear_count();
		@(posedge clk);
		count_clr <= 1'b1;
		@(posedge clk);
		count_clr <= 1'b0;
	endtask

	task automatic wait_intrq(input int limit);
		int n;
		n = 0;
		@(posedge clk);
		while (!intrq) begin
			if (n == limit)
				give_up("intrq never rose");
			@(posedge clk);
			n++;
		end
	endtask

	task automatic wait_steps(input int steps, input int limit);
		int n;
		n = 0;
		@(posedge clk);
		while (fall_count < steps) begin
			if (n == limit)
				give_up("the head stopped stepping too early");
			@(posedge clk);
			n++;
		end
	endtask

	// polls the status register until busy drops
	task automatic wait_idle(input int limit);
		logic [7:0] st;
		int         n;
		n = 0;
		st = 8'hFF;
		while (st[0]) begin
			if (n == limit)
				give_up("busy never cleared");
			bus_read(`FDC_A_CMD, st);
			n++;
		end
	endtask

	// exp_st holds status bits 4, 5 and 2 and the read must also drop intrq
	task automatic read_status(input logic [2:0] exp_st);
		logic [7:0] st;
		bus_read(`FDC_A_CMD, st);
		check_value("status busy", 32'(st[0]), 32'd0);
		check_value("status bits 4 5 2", 32'({st[4], st[5], st[2]}), 32'(exp_st));
		// drive pins as they stand in the cycle of the read
		check_value("status bits 7 6 1", 32'({st[7], st[6], st[1]}),
			32'({ready_n, !wprot_n, !index_n}));
		@(posedge clk);
		check_value("intrq after status read", 32'(intrq), 32'd0);
	endtask

	task automatic load_table();
		// head_set head stuck data_wr data cmd track steps dir_n st{4,5,2}
		rows[0]  = '{1'b1, 8'd5, 1'b0, 1'b0, 8'd0, 8'h08, 8'd0, 8'd5, 1'b1, 3'b011};
		rows[1]  = '{1'b0, 8'd0, 1'b0, 1'b1, 8'd40, 8'h18, 8'd40, 8'd40, 1'b0, 3'b010};
		rows[2]  = '{1'b0, 8'd0, 1'b0, 1'b1, 8'd10, 8'h10, 8'd10, 8'd30, 1'b1, 3'b000};
		rows[3]  = '{1'b0, 8'd0, 1'b0, 1'b1, 8'd10, 8'h18, 8'd10, 8'd0, 1'b1, 3'b010};
		// step-in, step-out, step with track update
		rows[4]  = '{1'b0, 8'd0, 1'b0, 1'b0, 8'd0, 8'h58, 8'd11, 8'd1, 1'b0, 3'b010};
		rows[5]  = '{1'b0, 8'd0, 1'b0, 1'b0, 8'd0, 8'h78, 8'd10, 8'd1, 1'b1, 3'b010};
		rows[6]  = '{1'b0, 8'd0, 1'b0, 1'b0, 8'd0, 8'h38, 8'd9, 8'd1, 1'b1, 3'b010};
		// same without update so the head moves but track stays at 9
		rows[7]  = '{1'b0, 8'd0, 1'b0, 1'b0, 8'd0, 8'h48, 8'd9, 8'd1, 1'b0, 3'b010};
		rows[8]  = '{1'b0, 8'd0, 1'b0, 1'b0, 8'd0, 8'h28, 8'd9, 8'd1, 1'b0, 3'b010};
		rows[9]  = '{1'b0, 8'd0, 1'b0, 1'b0, 8'd0, 8'h60, 8'd9, 8'd1, 1'b1, 3'b000};
		// restore that never finds track 0
		rows[10] = '{1'b0, 8'd0, 1'b1, 1'b0, 8'd0, 8'h00, 8'd9, 8'd255, 1'b1, 3'b100};
		rows[11] = '{1'b0, 8'd0, 1'b0, 1'b0, 8'd0, 8'h08, 8'd0, 8'd0, 1'b1, 3'b011};
		// step-out while already at track 0
		rows[12] = '{1'b0, 8'd0, 1'b0, 1'b0, 8'd0, 8'h70, 8'd0, 8'd0, 1'b1, 3'b001};
	endtask

	initial begin
		row_t       r;
		logic [7:0] rd;
		int         i;
		int         held;
		int         start_pos;

		rst_n     <= 1'b0;
		cs_n      <= 1'b1;
		re_n      <= 1'b1;
		we_n      <= 1'b1;
		addr      <= 2'd0;
		din       <= 8'h00;
		ready_n   <= 1'b0;
		wprot_n   <= 1'b1;
		pos_load  <= 1'b0;
		pos_value <= 0;
		count_clr <= 1'b0;
		stuck     <= 1'b0;
		load_table();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("step_n after reset", 32'(step_n), 32'd1);
		check_value("dir_n after reset", 32'(dir_n), 32'd1);
		check_value("intrq after reset", 32'(intrq), 32'd0);
		check_value("hld after reset", 32'(hld), 32'd0);
		bus_read(`FDC_A_CMD, rd);
		check_value("busy after reset", 32'(rd[0]), 32'd0);
		bus_read(`FDC_A_TRACK, rd);
		check_value("track after reset", 32'(rd), 32'd0);

		for (i = 0; i < NROWS; i++) begin
			r = rows[i];
			@(posedge clk);
			stuck   <= r.stuck;
			// walk the ready and write protect pins through all four levels
			ready_n <= i[0];
			wprot_n <= !i[1];
			if (r.head_set) begin
				pos_load  <= 1'b1;
				pos_value <= int'(r.head_val);
			end
			@(posedge clk);
			pos_load <= 1'b0;
			// trk00_n follows the head two edges later
			repeat (3) @(posedge clk);
			if (r.data_wr)
				bus_write(`FDC_A_DATA, r.data_val);
			clear_count();
			bus_write(`FDC_A_CMD, r.cmd);
			wait_intrq(8000);
			check_value("step count", fall_count, 32'(r.exp_steps));
			check_value("dir_n", 32'(dir_n), 32'(r.exp_dir));
			check_value("hld", 32'(hld), 32'(r.cmd[3]));
			bus_read(`FDC_A_TRACK, rd);
			check_value("track", 32'(rd), 32'(r.exp_track));
			read_status(r.exp_st);
		end

		// D8 in the middle of a slow inward seek from track 0
		bus_write(`FDC_A_DATA, 8'd79);
		clear_count();
		bus_write(`FDC_A_CMD, 8'h1B);
		wait_steps(5, 2000);
		// the engine is busy so this track write is dropped
		bus_write(`FDC_A_TRACK, 8'h55);
		bus_write(`FDC_A_CMD, 8'hD8);
		wait_intrq(50);
		repeat (8) @(posedge clk);
		held = fall_count;
		repeat (300) @(posedge clk);
		check_value("step count after D8", fall_count, held);
		check_value("head after D8", head_pos, held);
		bus_read(`FDC_A_TRACK, rd);
		check_value("track after D8", 32'(rd), held);
		read_status(3'b010);

		// D0 stops the same seek with no interrupt
		start_pos = head_pos;
		clear_count();
		bus_write(`FDC_A_CMD, 8'h1B);
		wait_steps(3, 2000);
		bus_write(`FDC_A_CMD, 8'hD0);
		// intrq stays low while no status read could have cleared it
		repeat (8) begin
			@(posedge clk);
			check_value("intrq after D0", 32'(intrq), 32'd0);
		end
		wait_idle(50);
		repeat (8) @(posedge clk);
		held = fall_count;
		repeat (300) @(posedge clk);
		check_value("step count after D0", fall_count, held);
		check_value("head after D0", head_pos, start_pos + held);
		bus_read(`FDC_A_TRACK, rd);
		check_value("track after D0", 32'(rd), start_pos + held);

		// a restore written during a seek is ignored and the seek still ends on 20
		start_pos = head_pos;
		bus_write(`FDC_A_DATA, 8'd20);
		clear_count();
		bus_write(`FDC_A_CMD, 8'h10);
		wait_steps(2, 500);
		bus_write(`FDC_A_CMD, 8'h08);
		wait_intrq(4000);
		check_value("step count to 20", fall_count, 20 - start_pos);
		check_value("head at 20", head_pos, 32'd20);
		check_value("hld after ignored command", 32'(hld), 32'd0);
		bus_read(`FDC_A_TRACK, rd);
		check_value("track at 20", 32'(rd), 32'd20);
		read_status(3'b000);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== src/fdc_top.sv ====
// floppy controller top with type I and force interrupt only; no read, write or DMA path
module fdc_top import fdc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cs_n,
	input  logic      re_n,
	input  logic      we_n,
	input  fdc_addr_t addr,
	input  fdc_byte_t din,
	output fdc_byte_t dout,
	output logic      intrq,
	output logic      step_n,
	output logic      dir_n,
	input  logic      trk00_n,
	input  logic      index_n,
	input  logic      ready_n,
	input  logic      wprot_n,
	output logic      hld
);

	fdc_byte_t status;
	fdc_byte_t cmd;
	fdc_byte_t track;
	fdc_byte_t data;
	fdc_byte_t track_next;
	logic      cmd_start;
	logic      status_read;
	logic      busy_eng;
	logic      track_load;
	logic      seek_err;
	logic      done;

	// host bus and registers
	fdc_host_regs u_host_regs (
		.clk(clk), .rst_n(rst_n),
		.cs_n(cs_n), .re_n(re_n), .we_n(we_n), .addr(addr), .din(din), .dout(dout),
		.status(status), .busy_eng(busy_eng),
		.track_load(track_load), .track_next(track_next),
		.cmd_start(cmd_start), .cmd(cmd), .track(track), .data(data),
		.status_read(status_read)
	);

	// head stepping
	fdc_seek_engine u_seek_engine (
		.clk(clk), .rst_n(rst_n),
		.cmd_start(cmd_start), .cmd(cmd), .track(track), .data(data),
		.trk00_n(trk00_n), .step_n(step_n), .dir_n(dir_n),
		.track_load(track_load), .track_next(track_next),
		.busy_eng(busy_eng), .seek_err(seek_err), .done(done)
	);

	// status byte, hld and intrq
	fdc_status_irq u_status_irq (
		.clk(clk), .rst_n(rst_n),
		.cmd_start(cmd_start), .cmd(cmd), .status_read(status_read),
		.busy_eng(busy_eng), .seek_err(seek_err), .done(done),
		.ready_n(ready_n), .wprot_n(wprot_n), .trk00_n(trk00_n), .index_n(index_n),
		.status(status), .hld(hld), .intrq(intrq)
	);

endmodule

// ==== src/fdc_status_irq.sv ====
// type I status byte, head load and intrq; the CRC bit 3 reads 0 as no ID field is ever read
module fdc_status_irq import fdc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cmd_start,
	input  fdc_byte_t cmd,
	input  logic      status_read,
	input  logic      busy_eng,
	input  logic      seek_err,
	input  logic      done,
	input  logic      ready_n,
	input  logic      wprot_n,
	input  logic      trk00_n,
	input  logic      index_n,
	output fdc_byte_t status,
	output logic      hld,
	output logic      intrq
);

	logic is_force;

	assign is_force = cmd[7:4] == 4'hD;

	// head load follows the h bit of every type I command
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			hld <= 1'b0;
		else if (cmd_start && !cmd[7])
			hld <= cmd[3];
	end

	// interrupt request
	// a new start clears it, except D8 which raises it at once
	// done sets it unless the command was a force interrupt
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			intrq <= 1'b0;
		else if (cmd_start)
			intrq <= is_force && cmd[3];
		else if (done && !is_force)
			intrq <= 1'b1;
		else if (status_read)
			intrq <= 1'b0;
	end

	always_comb begin
		status[7] = ready_n;
		status[6] = !wprot_n;
		status[5] = hld;
		status[4] = seek_err;
		status[3] = 1'b0;
		status[2] = !trk00_n;
		status[1] = !index_n;
		// busy covers the cycle before the engine leaves idle
		status[0] = busy_eng || cmd_start;
	end

endmodule

// ==== src/fdc_seek_engine.sv ====
// type I head positioning; the verify bit is ignored and all step timing is counted in clk cycles
`include "fdc_settings.svh"

module fdc_seek_engine import fdc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cmd_start,
	input  fdc_byte_t cmd,
	input  fdc_byte_t track,
	input  fdc_byte_t data,
	input  logic      trk00_n,
	output logic      step_n,
	output logic      dir_n,
	output logic      track_load,
	output fdc_byte_t track_next,
	output logic      busy_eng,
	output logic      seek_err,
	output logic      done
);

	seek_state_t state;
	// shared timer for pulse width and step period
	logic [7:0]  timer;
	// steps taken by this command bound the restore
	logic [7:0]  step_cnt;
	logic [7:0]  step_period;

	// command classes
	logic        is_force;
	logic        is_restore;
	logic        is_seek;
	logic        is_step_cls;

	// decision for the next move
	logic        decide;
	logic        ev_step;
	logic        ev_in;
	logic        ev_load;
	logic        ev_err;
	fdc_byte_t   ev_track;

	assign is_force    = cmd[7:4] == 4'hD;
	assign is_restore  = cmd[7:4] == 4'h0;
	assign is_seek     = cmd[7:4] == 4'h1;
	// step, step-in and step-out share 001x, 010x, 011x
	assign is_step_cls = !cmd[7] && cmd[6:5] != 2'b00;

	// base * (rate + 1)
	assign step_period = 8'(`FDC_STEP_BASE) * {6'd0, cmd[1:0]} + 8'(`FDC_STEP_BASE);

	// decide at a type I start and after each restore or seek step
	// step commands take one step and then end
	assign decide = (state == idle && cmd_start && !is_force) ||
		(state == step_wait && timer == 8'd0 && !is_step_cls);

	always_comb begin
		ev_step  = 1'b0;
		ev_in    = !dir_n;
		ev_load  = 1'b0;
		ev_err   = 1'b0;
		ev_track = track;
		if (is_restore) begin
			// restore always moves outward
			ev_in = 1'b0;
			if (!trk00_n) begin
				ev_load  = 1'b1;
				ev_track = '0;
			end else if (step_cnt == 8'(`FDC_RESTORE_LIMIT)) begin
				ev_err = 1'b1;
			end else begin
				ev_step = 1'b1;
			end
		end else if (is_seek) begin
			// nothing to do when already on target
			if (track != data) begin
				ev_in = data > track;
				if (!ev_in && !trk00_n) begin
					ev_load  = 1'b1;
					ev_track = '0;
				end else begin
					ev_step  = 1'b1;
					ev_load  = 1'b1;
					ev_track = ev_in ? track + 8'd1 : track - 8'd1;
				end
			end
		end else begin
			// plain step keeps the last direction
			if (cmd[6:5] == 2'b10)
				ev_in = 1'b1;
			else if (cmd[6:5] == 2'b11)
				ev_in = 1'b0;
			if (!ev_in && !trk00_n) begin
				// head already at track 0
				ev_load  = 1'b1;
				ev_track = '0;
			end else begin
				ev_step  = 1'b1;
				ev_load  = cmd[4];
				ev_track = ev_in ? track + 8'd1 : track - 8'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= idle;
			step_n     <= 1'b1;
			dir_n      <= 1'b1;
			timer      <= '0;
			step_cnt   <= '0;
			track_load <= 1'b0;
			seek_err   <= 1'b0;
		end else begin
			track_load <= 1'b0;
			if (cmd_start && is_force) begin
				// abort drops the strobe right away
				state  <= finish;
				step_n <= 1'b1;
			end else if (decide) begin
				track_load <= ev_load;
				// error flag is cleared at each type I start
				if (state == idle)
					seek_err <= ev_err;
				else if (ev_err)
					seek_err <= 1'b1;
				if (ev_step) begin
					state    <= step_low;
					step_n   <= 1'b0;
					dir_n    <= !ev_in;
					timer    <= 8'(`FDC_STEP_WIDTH - 1);
					step_cnt <= step_cnt + 8'd1;
				end else begin
					state <= finish;
				end
			end else begin
				case (state)
					step_low: begin
						if (timer == 8'd0) begin
							step_n <= 1'b1;
							timer  <= step_period - 8'd1;
							state  <= step_wait;
						end else begin
							timer <= timer - 8'd1;
						end
					end
					step_wait: begin
						// only step commands arrive here with an expired timer
						if (timer == 8'd0)
							state <= finish;
						else
							timer <= timer - 8'd1;
					end
					finish: begin
						state    <= idle;
						step_cnt <= '0;
					end
					default: ;
				endcase
			end
		end
	end

	// value written to the track register with track_load
	always_ff @(posedge clk) begin
		if (decide)
			track_next <= ev_track;
	end

	assign busy_eng = state != idle;
	assign done     = state == finish;

	a_step_low_state: assert property (
		@(posedge clk) disable iff (!rst_n)
		!step_n |-> state == step_low
	);

	a_step_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		!step_n |-> busy_eng
	);

endmodule

// ==== src/fdc_host_regs.sv ====
// host side registers; strobes are sampled on clk, so each low pulse must last at least one cycle
`include "fdc_settings.svh"

module fdc_host_regs import fdc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cs_n,
	input  logic      re_n,
	input  logic      we_n,
	input  fdc_addr_t addr,
	input  fdc_byte_t din,
	output fdc_byte_t dout,
	input  fdc_byte_t status,
	input  logic      busy_eng,
	input  logic      track_load,
	input  fdc_byte_t track_next,
	output logic      cmd_start,
	output fdc_byte_t cmd,
	output fdc_byte_t track,
	output fdc_byte_t data,
	output logic      status_read
);

	// previous strobe levels for edge detection
	logic      we_q;
	logic      re_q;
	logic      write_rq;
	logic      read_rq;
	// busy as the host sees it, includes the pending start cycle
	logic      busy;
	logic      cmd_free;
	logic      cmd_kind_ok;
	fdc_byte_t sector;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			we_q <= 1'b1;
			re_q <= 1'b1;
		end else begin
			we_q <= we_n;
			re_q <= re_n;
		end
	end

	// falling edges while selected
	assign write_rq = !cs_n && we_q && !we_n;
	assign read_rq  = !cs_n && re_q && !re_n;

	assign busy = busy_eng || cmd_start;

	// a new command needs an idle engine and no start in flight
	// force interrupt (upper nibble D) always gets through
	assign cmd_free = !busy || din[7:4] == 4'hD;
	// only type I and type IV codes start anything
	assign cmd_kind_ok = !din[7] || din[7:4] == 4'hD;

	// command register and start pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd       <= '0;
			cmd_start <= 1'b0;
		end else begin
			cmd_start <= 1'b0;
			if (write_rq && addr == `FDC_A_CMD && cmd_free && cmd_kind_ok) begin
				cmd       <= din;
				cmd_start <= 1'b1;
			end
		end
	end

	// track register, engine update has priority over the host
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			track <= '0;
		end else if (track_load) begin
			track <= track_next;
		end else if (write_rq && addr == `FDC_A_TRACK && !busy) begin
			track <= din;
		end
	end

	// sector register, host access only since there is no sector command
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sector <= 8'h01;
		end else if (write_rq && addr == `FDC_A_SECTOR && !busy) begin
			sector <= din;
		end
	end

	// data register doubles as the seek target
	// written at any time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data <= '0;
		end else if (write_rq && addr == `FDC_A_DATA) begin
			data <= din;
		end
	end

	// read mux, bus idles at all ones
	always_comb begin
		dout = '1;
		if (!cs_n && !re_n) begin
			case (addr)
				`FDC_A_CMD:    dout = status;
				`FDC_A_TRACK:  dout = track;
				`FDC_A_SECTOR: dout = sector;
				`FDC_A_DATA:   dout = data;
				default:       dout = '1;
			endcase
		end
	end

	// one pulse per status read, used to drop intrq
	assign status_read = read_rq && addr == `FDC_A_CMD;

	// a non-force start must find the engine idle
	a_start_not_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		cmd_start |-> (!busy_eng || cmd[7:4] == 4'hD)
	);

endmodule

// ==== src/fdc_pkg.sv ====
// shared types of the floppy controller; the seek states are ordered as the engine walks them
package fdc_pkg;

	// register and host bus byte
	typedef logic [7:0] fdc_byte_t;

	// host register address, 4 registers
	typedef logic [1:0] fdc_addr_t;

	// type I engine states
	// idle       waiting for a command start
	// step_low   step strobe held low
	// step_wait  step rate period after the strobe
	// finish     one cycle that raises done
	typedef enum logic [1:0] {
		idle,
		step_low,
		step_wait,
		finish
	} seek_state_t;

endpackage

// ==== include/fdc_settings.svh ====
// register map and step timing; all times are in clk cycles, the period math assumes 8-bit counters
`ifndef FDC_SETTINGS_SVH
`define FDC_SETTINGS_SVH

// host register addresses
// status shares the command address, reads give status and writes give a command
`define FDC_A_CMD    2'd0
`define FDC_A_TRACK  2'd1
`define FDC_A_SECTOR 2'd2
`define FDC_A_DATA   2'd3

// step pulse low time
`define FDC_STEP_WIDTH 4

// base step period, multiplied by (rate field + 1)
// keep base * 4 below 256 so the period fits the engine timer
`define FDC_STEP_BASE 16

// outward steps a restore may take before it reports a seek error
// must fit in 8 bits
`define FDC_RESTORE_LIMIT 255

`endif
